//--- dct_vec_rot.f
dct_rot_pkg.sv
bank_ram.sv
frame_writer.sv
pair_reader.sv
pair_skid_buffer.sv
dct_vec_rot.sv
dct_vec_rot_properties.sv
tb_dct_vec_rot.sv

//--- Bender.yml
package:
  name: dct_vec_rot

sources:
  - dct_rot_pkg.sv
  - bank_ram.sv
  - frame_writer.sv
  - pair_reader.sv
  - pair_skid_buffer.sv
  - dct_vec_rot.sv
  - target: test
    files:
      - dct_vec_rot_properties.sv
      - tb_dct_vec_rot.sv

//--- tb_dct_vec_rot.sv
// self-checking testbench for dct_vec_rot at SAMPLE_W 16 and MAX_LOG2 6
// expected pairs come from a natural-order model rebuilt from each input frame
// stops at the first mismatch, expired wait or bound assertion failure
module tb_dct_vec_rot;

	localparam int sample_w = 16;
	localparam int max_log2 = 6;
	localparam int log2_w = $clog2(max_log2 + 1);
	localparam int timeout_cycles = 2000;
	localparam int num_tests = 6;

	// one row of the stimulus table
	typedef struct {
		string name;
		int    log2;
		int    frames;
		bit    gaps;
		bit    ready_rand;
	} test_entry_t;

	test_entry_t         tests [num_tests];
	logic                clk;
	logic                rst_n_sync;
	logic                in_valid;
	logic                in_ready;
	logic                in_sop;
	logic                in_eop;
	logic [sample_w-1:0] in_real;
	logic [sample_w-1:0] in_imag;
	logic [log2_w-1:0]   fft_log2;
	logic                out_valid;
	logic                out_ready;
	logic                out_sop;
	logic                out_eop;
	logic [sample_w-1:0] out_real;
	logic [sample_w-1:0] out_imag;
	logic [sample_w-1:0] out_real_rev;
	logic [sample_w-1:0] out_imag_rev;
	logic [31:0]         data_rng;
	logic [31:0]         ready_rng;
	bit                  ready_rand;
	int                  cycle;
	int                  eop_cycle;
	string               cur_test;
	// expected {real, imag} per beat, primary and partner
	logic [31:0]         exp_prim [$];
	logic [31:0]         exp_part [$];

	dct_vec_rot #(.SAMPLE_W(sample_w), .MAX_LOG2(max_log2)) DUT (
		.clk(clk), .rst_n_sync(rst_n_sync),
		.in_valid(in_valid), .in_ready(in_ready), .in_sop(in_sop), .in_eop(in_eop),
		.in_real(in_real), .in_imag(in_imag), .fft_log2(fft_log2),
		.out_valid(out_valid), .out_ready(out_ready), .out_sop(out_sop), .out_eop(out_eop),
		.out_real(out_real), .out_imag(out_imag),
		.out_real_rev(out_real_rev), .out_imag_rev(out_imag_rev)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// index reversed over the frame's own bit count
	function automatic int bit_reverse(input int value, input int bits);
		int result;
		result = 0;
		for (int b = 0; b < bits; b++)
			result = (result << 1) | ((value >> b) & 1);
		return result;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("%s: gave up waiting for %s", cur_test, what);
		$display("Test failed");
		$fatal(1);
	endtask

	// ----------------------------------------
	// clock, cycle count, back-pressure
	// ----------------------------------------
	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// ready about half the time in random mode
	always @(posedge clk)
	begin
		ready_rng = lcg_next(ready_rng);
		out_ready <= ready_rand ? ready_rng[16] : 1'b1;
	end

	// a bound assertion failure ends the run as well
	always @(negedge clk)
	begin
		if (DUT.u_properties.error_count != 0)
		begin
			$display("%s: a bound assertion on the DUT did not hold", cur_test);
			$display("Test failed");
			$fatal(1);
		end
	end

	// builds the expected pairs first, then streams the bit-reversed frame
	task automatic send_frame(input int log2, input bit gaps);
		int          n;
		int          waited;
		logic [31:0] words [64];
		logic [31:0] natural [64];
		n = 1 << log2;
		for (int i = 0; i < n; i++)
		begin
			data_rng = lcg_next(data_rng);
			words[i] = data_rng;
			natural[bit_reverse(i, log2)] = data_rng;
		end
		// beat k pairs X[k] with X[(N-k) mod N]
		for (int k = 0; k < n; k++)
		begin
			exp_prim.push_back(natural[k]);
			exp_part.push_back(natural[(n - k) % n]);
		end
		for (int i = 0; i < n; i++)
		begin
			if (gaps)
			begin
				data_rng = lcg_next(data_rng);
				// one idle cycle now and then
				if (data_rng[20])
				begin
					@(posedge clk);
					in_valid <= 1'b0;
				end
			end
			@(posedge clk);
			in_valid <= 1'b1;
			in_sop   <= (i == 0);
			in_eop   <= (i == n - 1);
			in_real  <= words[i][31:16];
			in_imag  <= words[i][15:0];
			fft_log2 <= log2_w'(log2);
			// accepted on the next rising edge once ready is seen
			waited = 0;
			@(negedge clk);
			while (!in_ready)
			begin
				waited++;
				if (waited > timeout_cycles)
					stop_on_timeout("in_ready");
				@(negedge clk);
			end
		end
		eop_cycle = cycle;
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
		in_eop   <= 1'b0;
	endtask

	// one frame of output beats against the model
	task automatic receive_frame(input int log2, input bit check_latency);
		int          n;
		int          waited;
		logic [31:0] prim;
		logic [31:0] part;
		n = 1 << log2;
		for (int k = 0; k < n; k++)
		begin
			waited = 0;
			@(negedge clk);
			while (!(out_valid && out_ready))
			begin
				waited++;
				if (waited > timeout_cycles)
					stop_on_timeout($sformatf("output beat %0d", k));
				@(negedge clk);
			end
			if (k == 0 && check_latency)
				check_value("first beat latency", 32'd3, 32'(cycle - eop_cycle));
			prim = exp_prim.pop_front();
			part = exp_part.pop_front();
			check_value($sformatf("beat %0d primary", k), prim, {out_real, out_imag});
			check_value($sformatf("beat %0d partner", k), part, {out_real_rev, out_imag_rev});
			check_value($sformatf("beat %0d sop", k), 32'(k == 0), 32'(out_sop));
			check_value($sformatf("beat %0d eop", k), 32'(k == n - 1), 32'(out_eop));
			// input stays closed while the frame drains
			check_value($sformatf("beat %0d in_ready", k), 32'd0, 32'(in_ready));
		end
	endtask

	// ----------------------------------------
	// stimulus table and main loop
	// ----------------------------------------
	initial
	begin
		clk        = 1'b0;
		rst_n_sync = 1'b0;
		in_valid   = 1'b0;
		in_sop     = 1'b0;
		in_eop     = 1'b0;
		in_real    = '0;
		in_imag    = '0;
		fft_log2   = log2_w'(3);
		out_ready  = 1'b0;
		ready_rand = 1'b0;
		cycle      = 0;
		eop_cycle  = 0;
		cur_test   = "reset";
		data_rng   = 32'h06a0_d6e9;
		ready_rng  = lcg_next(32'h06a0_d6e9);
		// name, log2, frames, gaps, random ready
		tests[0] = '{"n8_ready_high", 3, 1, 1'b0, 1'b0};
		tests[1] = '{"n64_random_ready", 6, 1, 1'b0, 1'b1};
		tests[2] = '{"n16_back_to_back", 4, 3, 1'b0, 1'b0};
		tests[3] = '{"n32_self_pairs", 5, 1, 1'b1, 1'b0};
		tests[4] = '{"n16_gaps_random_ready", 4, 2, 1'b1, 1'b1};
		tests[5] = '{"n64_back_to_back_gaps", 6, 2, 1'b1, 1'b0};
		repeat (8) @(posedge clk);
		rst_n_sync <= 1'b1;
		for (int t = 0; t < num_tests; t++)
		begin
			cur_test   = tests[t].name;
			ready_rand = tests[t].ready_rand;
			fork
				for (int f = 0; f < tests[t].frames; f++)
					send_frame(tests[t].log2, tests[t].gaps);
				for (int f = 0; f < tests[t].frames; f++)
					receive_frame(tests[t].log2, !tests[t].ready_rand);
			join
			// no stray beat after the last eop
			repeat (4)
			begin
				@(negedge clk);
				check_value("beat after frame end", 32'd0, 32'(out_valid));
			end
		end
		if (DUT.u_properties.error_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

//--- dct_vec_rot_properties.sv
// bound into dct_vec_rot; output handshake and input gating checks
// reset is synchronous, checks are off while it is low
module dct_vec_rot_properties #(
	parameter int SAMPLE_W = 16
)
(
	input logic                clk,
	input logic                rst_n_sync,
	input logic                in_ready,
	input logic                out_valid,
	input logic                out_ready,
	input logic                out_sop,
	input logic                out_eop,
	input logic [SAMPLE_W-1:0] out_real,
	input logic [SAMPLE_W-1:0] out_imag,
	input logic [SAMPLE_W-1:0] out_real_rev,
	input logic [SAMPLE_W-1:0] out_imag_rev
);

	// failed assertions so far
	int error_count = 0;

	// ----------------------------------------
	// output stream
	// ----------------------------------------

	// stalled beat holds flags and data
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_sync)
		out_valid && !out_ready |=> out_valid && $stable(out_sop) && $stable(out_eop)
			&& $stable(out_real) && $stable(out_imag)
			&& $stable(out_real_rev) && $stable(out_imag_rev))
		else
		begin
			error_count++;
			$error("output beat changed while stalled");
		end

	// frame marks only on a valid beat, never both on one beat
	a_marks_with_valid: assert property (@(posedge clk) disable iff (!rst_n_sync)
		(out_sop || out_eop) |-> out_valid && !(out_sop && out_eop))
		else
		begin
			error_count++;
			$error("sop or eop without out_valid, or both on one beat");
		end

	// ----------------------------------------
	// input gating
	// ----------------------------------------

	// one frame held at a time, input closed until the last beat has left
	a_no_fill_during_output: assert property (@(posedge clk) disable iff (!rst_n_sync)
		out_valid && !(out_ready && out_eop) |=> !in_ready)
		else
		begin
			error_count++;
			$error("in_ready high before the last beat of the frame left");
		end

	// idle fill state right out of reset
	a_reset_state: assert property (@(posedge clk)
		$rose(rst_n_sync) |-> in_ready && !out_valid)
		else
		begin
			error_count++;
			$error("wrong state in first cycle after reset");
		end

endmodule

bind dct_vec_rot dct_vec_rot_properties #(.SAMPLE_W(SAMPLE_W)) u_properties (
	.clk(clk), .rst_n_sync(rst_n_sync), .in_ready(in_ready),
	.out_valid(out_valid), .out_ready(out_ready), .out_sop(out_sop), .out_eop(out_eop),
	.out_real(out_real), .out_imag(out_imag),
	.out_real_rev(out_real_rev), .out_imag_rev(out_imag_rev)
);

//--- dct_vec_rot.sv
// frame reorder for the FFT-based DCT, bit-reversed in, natural pairs out
// beat k carries X[k] and X[(N-k) mod N]; one frame is held at a time
module dct_vec_rot
	import dct_rot_pkg::*;
#(
	parameter int SAMPLE_W = SAMPLE_W_DEFAULT,
	parameter int MAX_LOG2 = MAX_LOG2_DEFAULT,
	localparam int log2_w = log2_width(MAX_LOG2),
	localparam int addr_w = MAX_LOG2 - 1
)
(
	input  logic                clk,
	input  logic                rst_n_sync,
	// input stream
	input  logic                in_valid,
	output logic                in_ready,
	input  logic                in_sop,
	input  logic                in_eop,
	input  logic [SAMPLE_W-1:0] in_real,
	input  logic [SAMPLE_W-1:0] in_imag,
	input  logic [log2_w-1:0]   fft_log2,
	// output stream
	output logic                out_valid,
	input  logic                out_ready,
	output logic                out_sop,
	output logic                out_eop,
	output logic [SAMPLE_W-1:0] out_real,
	output logic [SAMPLE_W-1:0] out_imag,
	output logic [SAMPLE_W-1:0] out_real_rev,
	output logic [SAMPLE_W-1:0] out_imag_rev
);

	logic                  fill_en;
	logic                  frame_done;
	logic [log2_w-1:0]     frame_log2;
	logic                  lo_wr_en;
	logic                  hi_wr_en;
	logic [addr_w-1:0]     wr_addr;
	logic [2*SAMPLE_W-1:0] wr_data;
	logic [addr_w-1:0]     lo_rd_addr;
	logic [addr_w-1:0]     hi_rd_addr;
	logic [2*SAMPLE_W-1:0] lo_rd_data;
	logic [2*SAMPLE_W-1:0] hi_rd_data;
	logic                  rd_issue;
	pair_sel_t             rd_sel;
	logic                  rd_sop;
	logic                  rd_eop;
	logic                  issue_ok;
	logic                  out_idle;

	assign in_ready = fill_en;

	// ----------------------------------------
	// write side
	// ----------------------------------------
	frame_writer #(.SAMPLE_W(SAMPLE_W), .MAX_LOG2(MAX_LOG2)) u_writer (
		.clk(clk), .rst_n_sync(rst_n_sync),
		.in_valid(in_valid), .in_sop(in_sop), .in_eop(in_eop),
		.in_real(in_real), .in_imag(in_imag), .fft_log2(fft_log2),
		.fill_en(fill_en), .frame_done(frame_done), .frame_log2(frame_log2),
		.lo_wr_en(lo_wr_en), .hi_wr_en(hi_wr_en),
		.wr_addr(wr_addr), .wr_data(wr_data)
	);

	// indices 0 .. N/2-1
	bank_ram #(.SAMPLE_W(SAMPLE_W), .MAX_LOG2(MAX_LOG2)) u_lo_bank (
		.clk(clk), .wr_en(lo_wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(lo_rd_addr), .rd_data(lo_rd_data)
	);

	// indices N/2 .. N-1
	bank_ram #(.SAMPLE_W(SAMPLE_W), .MAX_LOG2(MAX_LOG2)) u_hi_bank (
		.clk(clk), .wr_en(hi_wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(hi_rd_addr), .rd_data(hi_rd_data)
	);

	// ----------------------------------------
	// read side
	// ----------------------------------------
	pair_reader #(.MAX_LOG2(MAX_LOG2)) u_reader (
		.clk(clk), .rst_n_sync(rst_n_sync),
		.frame_done(frame_done), .frame_log2(frame_log2),
		.issue_ok(issue_ok), .out_idle(out_idle), .fill_en(fill_en),
		.lo_rd_addr(lo_rd_addr), .hi_rd_addr(hi_rd_addr),
		.rd_issue(rd_issue), .rd_sel(rd_sel), .rd_sop(rd_sop), .rd_eop(rd_eop)
	);

	pair_skid_buffer #(.SAMPLE_W(SAMPLE_W)) u_skid (
		.clk(clk), .rst_n_sync(rst_n_sync),
		.rd_issue(rd_issue), .rd_sel(rd_sel), .rd_sop(rd_sop), .rd_eop(rd_eop),
		.lo_data(lo_rd_data), .hi_data(hi_rd_data), .out_ready(out_ready),
		.issue_ok(issue_ok), .out_idle(out_idle),
		.out_valid(out_valid), .out_sop(out_sop), .out_eop(out_eop),
		.out_real(out_real), .out_imag(out_imag),
		.out_real_rev(out_real_rev), .out_imag_rev(out_imag_rev)
	);

endmodule

//--- pair_skid_buffer.sv
// two-beat output buffer behind the banks' one-cycle read latency
// issue_ok counts the slot freed by this cycle's transfer
module pair_skid_buffer
	import dct_rot_pkg::*;
#(
	parameter int SAMPLE_W = SAMPLE_W_DEFAULT,
	localparam int word_w = 2 * SAMPLE_W
)
(
	input  logic                clk,
	input  logic                rst_n_sync,
	input  logic                rd_issue,
	input  pair_sel_t           rd_sel,
	input  logic                rd_sop,
	input  logic                rd_eop,
	input  logic [word_w-1:0]   lo_data,
	input  logic [word_w-1:0]   hi_data,
	input  logic                out_ready,
	output logic                issue_ok,
	output logic                out_idle,
	output logic                out_valid,
	output logic                out_sop,
	output logic                out_eop,
	output logic [SAMPLE_W-1:0] out_real,
	output logic [SAMPLE_W-1:0] out_imag,
	output logic [SAMPLE_W-1:0] out_real_rev,
	output logic [SAMPLE_W-1:0] out_imag_rev
);

	// issue tags, one cycle late to meet the RAM data
	logic              issue_q;
	pair_sel_t         sel_q;
	logic              sop_q;
	logic              eop_q;
	logic [word_w-1:0] prim;
	logic [word_w-1:0] part;
	// two slots, primary and partner each
	logic [word_w-1:0] prim_mem [2];
	logic [word_w-1:0] part_mem [2];
	logic              sop_mem [2];
	logic              eop_mem [2];
	logic              wr_ptr;
	logic              rd_ptr;
	logic [1:0]        count;
	logic [2:0]        pending;
	logic              pop;

	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
			issue_q <= 1'b0;
		else
			issue_q <= rd_issue;
		sel_q <= rd_sel;
		sop_q <= rd_sop;
		eop_q <= rd_eop;
	end

	// beat from the two bank words
	always_comb
	begin
		case (sel_q)
			sel_swapped:   begin prim = hi_data; part = lo_data; end
			sel_low_both:  begin prim = lo_data; part = lo_data; end
			sel_high_both: begin prim = hi_data; part = hi_data; end
			default:       begin prim = lo_data; part = hi_data; end
		endcase
	end

	// ----------------------------------------
	// buffer and flow control
	// ----------------------------------------
	assign out_valid = (count != 2'd0);
	assign pop       = out_valid && out_ready;

	// occupancy once this cycle's push and pop settle
	assign pending  = 3'(count) + 3'(issue_q) - 3'(pop);
	assign issue_ok = (pending < 3'd2);
	assign out_idle = (count == 2'd0) && !issue_q;

	always_ff @(posedge clk)
	begin
		if (issue_q)
		begin
			prim_mem[wr_ptr] <= prim;
			part_mem[wr_ptr] <= part;
			sop_mem[wr_ptr]  <= sop_q;
			eop_mem[wr_ptr]  <= eop_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (issue_q)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			count <= count + 2'(issue_q) - 2'(pop);
		end
	end

	// head slot, held while ready is low
	assign out_sop      = out_valid && sop_mem[rd_ptr];
	assign out_eop      = out_valid && eop_mem[rd_ptr];
	assign out_real     = prim_mem[rd_ptr][word_w-1:SAMPLE_W];
	assign out_imag     = prim_mem[rd_ptr][SAMPLE_W-1:0];
	assign out_real_rev = part_mem[rd_ptr][word_w-1:SAMPLE_W];
	assign out_imag_rev = part_mem[rd_ptr][SAMPLE_W-1:0];

endmodule

//--- pair_reader.sv
// drain sweep; frame_log2 must hold from frame_done until the last issue
// input is refused until the previous frame has fully left the output buffer
module pair_reader
	import dct_rot_pkg::*;
#(
	parameter int MAX_LOG2 = MAX_LOG2_DEFAULT,
	localparam int log2_w = log2_width(MAX_LOG2),
	localparam int addr_w = MAX_LOG2 - 1
)
(
	input  logic              clk,
	input  logic              rst_n_sync,
	input  logic              frame_done,
	input  logic [log2_w-1:0] frame_log2,
	input  logic              issue_ok,
	input  logic              out_idle,
	output logic              fill_en,
	output logic [addr_w-1:0] lo_rd_addr,
	output logic [addr_w-1:0] hi_rd_addr,
	output logic              rd_issue,
	output pair_sel_t         rd_sel,
	output logic              rd_sop,
	output logic              rd_eop
);

	frame_state_t        state;
	// beat index within the frame
	logic [MAX_LOG2-1:0] k;
	logic [MAX_LOG2:0]   k_ext;
	logic [MAX_LOG2:0]   n_full;
	logic [MAX_LOG2:0]   n_half;
	logic [MAX_LOG2:0]   lo_full;
	logic [MAX_LOG2:0]   hi_full;
	logic                active;
	logic                last;

	assign k_ext  = {1'b0, k};
	assign n_full = (MAX_LOG2 + 1)'(1) << frame_log2;
	assign n_half = n_full >> 1;
	assign last   = (k_ext == n_full - 1'b1);

	// sweep starts in the frame_done cycle itself
	assign active   = (state == st_drain) || frame_done;
	assign rd_issue = active && issue_ok;

	// no new sample while a frame is pending, draining or still in the buffer
	assign fill_en = (state == st_fill) && !frame_done && out_idle;

	assign rd_sop = (k == '0);
	assign rd_eop = last;

	// ----------------------------------------
	// address and code per beat
	// ----------------------------------------
	always_comb
	begin
		lo_full = '0;
		hi_full = '0;
		rd_sel  = sel_straight;
		if (k_ext == '0)
		begin
			// X[0] pairs with itself
			rd_sel = sel_low_both;
		end
		else if (k_ext < n_half)
		begin
			// outward on low, back on high
			lo_full = k_ext;
			hi_full = n_half - k_ext;
			rd_sel  = sel_straight;
		end
		else if (k_ext == n_half)
		begin
			// X[N/2] is high word 0, pairs with itself
			rd_sel = sel_high_both;
		end
		else
		begin
			// back on low, outward on high
			lo_full = n_full - k_ext;
			hi_full = k_ext - n_half;
			rd_sel  = sel_swapped;
		end
	end

	assign lo_rd_addr = lo_full[addr_w-1:0];
	assign hi_rd_addr = hi_full[addr_w-1:0];

	// ----------------------------------------
	// frame FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			state <= st_fill;
			k     <= '0;
		end
		else
		begin
			case (state)
				st_fill:
				begin
					// k = 0 may already be issued here
					if (frame_done)
						state <= st_drain;
					if (rd_issue)
						k <= k + 1'b1;
				end
				st_drain:
				begin
					if (rd_issue)
					begin
						if (last)
						begin
							k     <= '0;
							state <= st_fill;
						end
						else
							k <= k + 1'b1;
					end
				end
				default:
				begin
					state <= st_fill;
					k     <= '0;
				end
			endcase
		end
	end

endmodule

//--- frame_writer.sv
// input side; the source sends exactly N samples from sop to eop
// sizes outside MIN_LOG2..MAX_LOG2 are clamped to the nearest limit
module frame_writer
	import dct_rot_pkg::*;
#(
	parameter int SAMPLE_W = SAMPLE_W_DEFAULT,
	parameter int MAX_LOG2 = MAX_LOG2_DEFAULT,
	localparam int log2_w = log2_width(MAX_LOG2),
	localparam int addr_w = MAX_LOG2 - 1
)
(
	input  logic                  clk,
	input  logic                  rst_n_sync,
	input  logic                  in_valid,
	input  logic                  in_sop,
	input  logic                  in_eop,
	input  logic [SAMPLE_W-1:0]   in_real,
	input  logic [SAMPLE_W-1:0]   in_imag,
	input  logic [log2_w-1:0]     fft_log2,
	input  logic                  fill_en,
	output logic                  frame_done,
	output logic [log2_w-1:0]     frame_log2,
	output logic                  lo_wr_en,
	output logic                  hi_wr_en,
	output logic [addr_w-1:0]     wr_addr,
	output logic [2*SAMPLE_W-1:0] wr_data
);

	// keep the requested size inside the supported range
	function automatic logic [log2_w-1:0] clamp_log2(input logic [log2_w-1:0] req);
		if (req < MIN_LOG2)
			return log2_w'(MIN_LOG2);
		if (req > MAX_LOG2)
			return log2_w'(MAX_LOG2);
		return req;
	endfunction

	logic                accept;
	// samples taken so far in this frame
	logic [MAX_LOG2-1:0] cnt;
	logic [MAX_LOG2-1:0] idx;
	logic [log2_w-1:0]   size_q;
	logic [log2_w-1:0]   size_cur;
	logic [MAX_LOG2-1:0] rev;
	logic [MAX_LOG2-1:0] half_mask;
	logic [MAX_LOG2-1:0] rev_in_bank;

	assign accept = in_valid && fill_en;

	// sop sample is always index 0 with its own size
	assign idx      = in_sop ? '0 : cnt;
	assign size_cur = in_sop ? clamp_log2(fft_log2) : size_q;

	// ----------------------------------------
	// bit reversal over the runtime size
	// ----------------------------------------
	always_comb
	begin
		rev = '0;
		for (int j = 0; j < MAX_LOG2; j++)
		begin
			if (j < size_cur)
				rev[size_cur - 1 - j] = idx[j];
		end
	end

	// top bit of the reversed index picks the bank
	assign half_mask   = MAX_LOG2'(1) << (size_cur - 1'b1);
	assign rev_in_bank = rev & ~half_mask;

	assign lo_wr_en = accept && ((rev & half_mask) == '0);
	assign hi_wr_en = accept && ((rev & half_mask) != '0);
	assign wr_addr  = rev_in_bank[addr_w-1:0];
	// real above imag
	assign wr_data  = {in_real, in_imag};

	assign frame_log2 = size_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			cnt        <= '0;
			size_q     <= log2_w'(MIN_LOG2);
			frame_done <= 1'b0;
		end
		else
		begin
			// one pulse after the eop write
			frame_done <= accept && in_eop;
			if (accept)
			begin
				cnt    <= idx + 1'b1;
				size_q <= size_cur;
			end
		end
	end

endmodule

//--- bank_ram.sv
// half-bank store, 2**(MAX_LOG2-1) words of {real, imag}
// read data is registered; same-address read and write returns the old word
module bank_ram #(
	parameter int SAMPLE_W = 16,
	parameter int MAX_LOG2 = 6,
	localparam int addr_w = MAX_LOG2 - 1,
	localparam int word_w = 2 * SAMPLE_W
)
(
	input  logic              clk,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  logic [word_w-1:0] wr_data,
	input  logic [addr_w-1:0] rd_addr,
	output logic [word_w-1:0] rd_data
);

	// half a frame at the largest size
	logic [word_w-1:0] mem [2**addr_w];

	// write port and registered read port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

//--- dct_rot_pkg.sv
// shared types and defaults for the DCT pair reorder buffer
// runtime frame sizes run from 2**MIN_LOG2 up to the MAX_LOG2 of the instance
package dct_rot_pkg;

	// ----------------------------------------
	// controller states
	// ----------------------------------------

	// one bit, fill after reset
	typedef enum logic {
		// banks accept the incoming frame
		st_fill,
		// banks are swept out as primary/partner pairs
		st_drain
	} frame_state_t;

	// ----------------------------------------
	// pair select codes
	// ----------------------------------------

	// how one beat is built from the two bank words
	typedef enum logic [1:0] {
		// primary from low bank, partner from high bank
		sel_straight,
		// primary from high bank, partner from low bank
		sel_swapped,
		// k = 0, X[0] twice
		sel_low_both,
		// k = N/2, X[N/2] twice
		sel_high_both
	} pair_sel_t;

	// ----------------------------------------
	// default sizes
	// ----------------------------------------

	// width of one real or imaginary part
	localparam int SAMPLE_W_DEFAULT = 16;
	// largest frame, N = 64
	localparam int MAX_LOG2_DEFAULT = 6;
	// smallest frame, N = 8
	localparam int MIN_LOG2 = 3;

	// bits needed to carry a log2 frame size up to max_log2
	function automatic int log2_width(input int max_log2);
		return $clog2(max_log2 + 1);
	endfunction

endpackage
